// ==== design/vicii_clk_pkg.sv ====
`default_nettype none

package vicii_clk_pkg;

    // phase accumulator word of the enable oscillators
    typedef logic [31:0] phase_t;

    // chip code handed to the video core
    typedef logic [1:0] chip_t;

    // dot index inside one phi cycle
    typedef logic [2:0] dot_count_t;

    // dot4x strobes seen inside one dot
    typedef logic [1:0] quarter_t;

    // dot4x strobes counted while waiting for lock
    typedef logic [7:0] lock_cnt_t;

    // ntsc, the common 6567 revision
    localparam chip_t chip_6567r8   = 2'd0;
    // early ntsc revision
    localparam chip_t chip_6567r56a = 2'd1;
    // pal
    localparam chip_t chip_6569     = 2'd2;
    // pal-n
    localparam chip_t chip_6572     = 2'd3;

    // increments are rate * 2^32 / 100 MHz, rounded down
    // 31.527954 MHz pal dot4x
    localparam phase_t dot4x_inc_pal  = 32'd1354115313;
    // 17.734475 MHz pal color4x
    localparam phase_t col4x_inc_pal  = 32'd761689901;
    // 32.727264 MHz ntsc dot4x
    localparam phase_t dot4x_inc_ntsc = 32'd1405625285;
    // 14.318180 MHz ntsc color4x
    localparam phase_t col4x_inc_ntsc = 32'd614961148;

    // one accumulator for dot4x, one for col4x
    localparam int nco_channels = 2;

    // oscillator counts as locked after this many dot4x strobes
    localparam lock_cnt_t lock_pulses = 8'd64;

endpackage : vicii_clk_pkg

`default_nettype wire

// ==== design/clock_nco.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_nco (
    input  wire logic sys_clock,
    input  wire logic internal_rst,
    input  wire logic nco_run,
    input  wire logic is_pal_latched,
    output logic      dot4x_en,
    output logic      col4x_en
);
    import vicii_clk_pkg::*;

    // channel 0 makes dot4x, channel 1 makes col4x
    phase_t [nco_channels-1:0] inc;
    phase_t [nco_channels-1:0] acc_q;
    logic   [nco_channels-1:0] carry_q;

    // increment pair picked by the standard latched during reset
    assign inc[0] = is_pal_latched ? dot4x_inc_pal : dot4x_inc_ntsc;
    assign inc[1] = is_pal_latched ? col4x_inc_pal : col4x_inc_ntsc;

    // accumulators sit at zero until the startup counter lets them run
    // each edge adds the increment, the carry out becomes the strobe
    always_ff @(posedge sys_clock) begin
        if (internal_rst || !nco_run) begin
            acc_q   <= '0;
            carry_q <= '0;
        end else begin
            for (int ch = 0; ch < nco_channels; ch++) begin
                // 33 bit add, msb is the wrap of the phase word
                {carry_q[ch], acc_q[ch]} <= {1'b0, acc_q[ch]} + {1'b0, inc[ch]};
            end
        end
    end

    // carries are registered, so each strobe lasts one cycle
    // and shows up the cycle after the wrapping edge
    assign dot4x_en = carry_q[0];
    assign col4x_en = carry_q[1];

    // the strobe count after n adds is floor(n * inc / 2^32)
    // since every accumulator starts from a phase of zero

    // dot4x increment is under half the phase range,
    // so two wraps in a row cannot happen
    a_dot4x_spaced: assert property (
        @(posedge sys_clock) disable iff (internal_rst)
        dot4x_en |=> !dot4x_en
    ) else $error("dot4x_en high in two consecutive cycles");

    // same holds for the slower color strobe
    a_col4x_spaced: assert property (
        @(posedge sys_clock) disable iff (internal_rst)
        col4x_en |=> !col4x_en
    ) else $error("col4x_en high in two consecutive cycles");

endmodule : clock_nco

`default_nettype wire

// ==== design/reset_release.sv ====
`timescale 1ns/1ps
`default_nettype none

module reset_release (
    input  wire logic sys_clock,
    input  wire logic internal_rst,
    input  wire logic nco_run,
    input  wire logic dot4x_en,
    output logic      rst
);
    import vicii_clk_pkg::*;

    // dot4x strobes seen since the oscillator started
    lock_cnt_t lock_cnt_q;
    logic      locked;

    // two stage synchronizer clocked by the dot4x strobe
    logic      stage1_q;
    logic      stage2_q;

    // lock is declared once enough strobes have come out
    assign locked = (lock_cnt_q == lock_pulses);

    always_ff @(posedge sys_clock) begin
        if (internal_rst || !nco_run) begin
            lock_cnt_q <= '0;
            stage1_q   <= 1'b0;
            stage2_q   <= 1'b0;
        end else if (dot4x_en) begin
            // counter parks at lock_pulses
            if (!locked) begin
                lock_cnt_q <= lock_cnt_q + 1'b1;
            end
            // a one enters on the strobe after lock
            stage1_q <= locked;
            // and reaches the output one strobe later
            stage2_q <= stage1_q;
        end
    end

    // core reset drops in the cycle after the strobe that loads stage two,
    // so the first free dot4x cycle lines up with the strobe grid
    assign rst = !stage2_q;

    // core reset only comes back through internal_rst
    // or a stopped oscillator on the edge before
    a_rst_rise_cause: assert property (
        @(posedge sys_clock) disable iff (internal_rst)
        $rose(rst) |-> $past(internal_rst || !nco_run)
    ) else $error("rst rose without internal_rst or a stopped oscillator");

    // once released the core reset holds low while the oscillator runs
    a_rst_stays_low: assert property (
        @(posedge sys_clock) disable iff (internal_rst)
        (!rst && nco_run) |=> !rst
    ) else $error("rst returned while nco_run stayed high");

endmodule : reset_release

`default_nettype wire

// ==== design/clockgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockgen #(
    // 21 gives about 21 ms of startup hold at 100 MHz
    parameter int startup_bits = 21
) (
    input  wire logic            sys_clock,
    input  wire logic            internal_rst,
    input  wire logic            is_pal,
    output logic                 dot4x_en,
    output logic                 col4x_en,
    output logic                 rst,
    output vicii_clk_pkg::chip_t chip
);
    import vicii_clk_pkg::*;

    // startup counter, one bit wider than the hold length
    logic [startup_bits:0] startup_q;

    // top bit of the counter lets the oscillator run
    logic                  nco_run;

    // video standard taken from the strap during reset
    logic                  pal_q;

    assign nco_run = startup_q[startup_bits];

    // counts 2^startup_bits edges after internal_rst drops,
    // then stops with only the top bit set
    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            startup_q <= '0;
        end else if (!nco_run) begin
            startup_q <= startup_q + 1'b1;
        end
    end

    // strap is sampled on every reset edge and frozen afterwards,
    // a later toggle of is_pal has no effect until the next reset
    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            pal_q <= is_pal;
        end
    end

    // only the two production chips are chosen by the strap
    assign chip = pal_q ? chip_6569 : chip_6567r8;

    // enable oscillator replacing the board pll
    clock_nco u_clock_nco (
        .sys_clock      (sys_clock),
        .internal_rst   (internal_rst),
        .nco_run        (nco_run),
        .is_pal_latched (pal_q),
        .dot4x_en       (dot4x_en),
        .col4x_en       (col4x_en)
    );

    // lock wait and strobe aligned core reset
    reset_release u_reset_release (
        .sys_clock    (sys_clock),
        .internal_rst (internal_rst),
        .nco_run      (nco_run),
        .dot4x_en     (dot4x_en),
        .rst          (rst)
    );

    // nothing may strobe before the startup hold has run out
    a_quiet_before_run: assert property (
        @(posedge sys_clock) disable iff (internal_rst)
        !nco_run |-> (rst && !dot4x_en && !col4x_en)
    ) else $error("strobes or core release seen before nco_run");

endmodule : clockgen

`default_nettype wire

// ==== design/dot_phase_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module dot_phase_gen (
    input  wire logic                 sys_clock,
    input  wire logic                 rst,
    input  wire logic                 dot4x_en,
    output logic                      dot_en,
    output logic                      phi_start,
    output logic                      phi2,
    output vicii_clk_pkg::dot_count_t dot_count
);
    import vicii_clk_pkg::*;

    // position inside the current dot, in dot4x strobes
    quarter_t   quarter_q;

    // dot index inside the phi cycle
    dot_count_t dot_cnt_q;
    dot_count_t dot_cnt_next;

    // 4th dot4x strobe of a dot
    logic       dot_tick;

    // registered outputs
    logic       dot_en_q;
    logic       phi_start_q;
    logic       phi2_q;

    assign dot_tick     = dot4x_en && (quarter_q == '1);
    // 3 bit add wraps from 7 back to 0
    assign dot_cnt_next = dot_cnt_q + 1'b1;

    always_ff @(posedge sys_clock) begin
        if (rst) begin
            quarter_q   <= '0;
            dot_cnt_q   <= '0;
            dot_en_q    <= 1'b0;
            phi_start_q <= 1'b0;
            phi2_q      <= 1'b0;
        end else begin
            // single cycle pulses follow the strobe edge
            dot_en_q    <= dot_tick;
            phi_start_q <= dot_tick && (dot_cnt_q == '1);
            if (dot4x_en) begin
                quarter_q <= quarter_q + 1'b1;
            end
            if (dot_tick) begin
                dot_cnt_q <= dot_cnt_next;
                // second half of the phi cycle covers dots 4 to 7
                phi2_q    <= dot_cnt_next[2];
            end
        end
    end

    assign dot_en    = dot_en_q;
    assign phi_start = phi_start_q;
    assign phi2      = phi2_q;
    assign dot_count = dot_cnt_q;

    // phi2 edges fall on dot boundaries only
    a_phi2_on_dot: assert property (
        @(posedge sys_clock) disable iff (rst)
        $changed(phi2) |-> dot_en
    ) else $error("phi2 changed outside a dot_en cycle");

endmodule : dot_phase_gen

`default_nettype wire

// ==== design/vicii_clock_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vicii_clock_top #(
    // length of the power-on hold, in powers of two of sys_clock
    parameter int startup_bits = 21
) (
    input  wire logic                 sys_clock,
    input  wire logic                 internal_rst,
    input  wire logic                 is_pal,
    output logic                      dot4x_en,
    output logic                      col4x_en,
    output logic                      rst,
    output vicii_clk_pkg::chip_t      chip,
    output logic                      dot_en,
    output logic                      phi_start,
    output logic                      phi2,
    output vicii_clk_pkg::dot_count_t dot_count
);

    // strobe oscillator, chip select and core reset
    clockgen #(
        .startup_bits (startup_bits)
    ) u_clockgen (
        .sys_clock    (sys_clock),
        .internal_rst (internal_rst),
        .is_pal       (is_pal),
        .dot4x_en     (dot4x_en),
        .col4x_en     (col4x_en),
        .rst          (rst),
        .chip         (chip)
    );

    // dot and phi timing built on the dot4x strobe,
    // held in reset until the oscillator is locked
    dot_phase_gen u_dot_phase_gen (
        .sys_clock (sys_clock),
        .rst       (rst),
        .dot4x_en  (dot4x_en),
        .dot_en    (dot_en),
        .phi_start (phi_start),
        .phi2      (phi2),
        .dot_count (dot_count)
    );

endmodule : vicii_clock_top

`default_nettype wire

// ==== bench/tb_vicii_clocks.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vicii_clocks;
    import vicii_clk_pkg::*;

    // short power-on hold so a run fits in a few thousand cycles
    localparam int startup_bits   = 8;
    localparam longint unsigned startup_edges = 64'd1 << startup_bits;
    // adds checked per run after the oscillator starts
    localparam int rate_window    = 4000;
    // 4 runs of (10 + 15 + 256 + 300 + 4000) plus margin
    localparam int timeout_cycles = 20000;
    // 64 strobes to lock, then two strobe aligned stages
    localparam longint unsigned release_strobes = 66;

    // target rates in Hz
    localparam longint unsigned dot4x_hz_pal  = 64'd31527954;
    localparam longint unsigned col4x_hz_pal  = 64'd17734475;
    localparam longint unsigned dot4x_hz_ntsc = 64'd32727264;
    localparam longint unsigned col4x_hz_ntsc = 64'd14318180;

    logic       sys_clock;
    logic       internal_rst;
    logic       is_pal;
    logic       dot4x_en;
    logic       col4x_en;
    logic       rst;
    chip_t      chip;
    logic       dot_en;
    logic       phi_start;
    logic       phi2;
    dot_count_t dot_count;

    // model state, updated on the rising edge from the inputs
    logic            started;
    logic            pal_ref;
    int              reset_edge_count;
    longint unsigned edges_since_release;

    // strobes counted by the checker since the last release
    longint unsigned dot4x_seen;
    longint unsigned col4x_seen;

    int          cycle_count;
    int          checks_done;
    int          value_errors;
    int          other_errors;
    logic [31:0] rng_state;

    vicii_clock_top #(
        .startup_bits (startup_bits)
    ) DUT (
        .sys_clock    (sys_clock),
        .internal_rst (internal_rst),
        .is_pal       (is_pal),
        .dot4x_en     (dot4x_en),
        .col4x_en     (col4x_en),
        .rst          (rst),
        .chip         (chip),
        .dot_en       (dot_en),
        .phi_start    (phi_start),
        .phi2         (phi2),
        .dot_count    (dot_count)
    );

    // 100 MHz
    always #5 sys_clock = ~sys_clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // phase step for a rate, rate * 2^32 / 100 MHz rounded down
    function automatic longint unsigned rate_increment(input longint unsigned hz);
        return (hz << 32) / 64'd100000000;
    endfunction

    // strobes issued after n adds from a zero phase
    function automatic longint unsigned strobes_after_adds(input longint unsigned n,
                                                           input longint unsigned inc);
        return (n * inc) >> 32;
    endfunction

    // add count whose strobe is the 66th, rst is low from the cycle after
    function automatic longint unsigned release_cycle(input longint unsigned inc);
        return ((release_strobes << 32) + inc - 1) / inc;
    endfunction

    // dot4x strobes the phase generator has seen before cycle n
    function automatic longint unsigned strobes_since_release(input longint unsigned n,
                                                              input longint unsigned inc,
                                                              input longint unsigned rel);
        if (n <= rel + 1) begin
            return 0;
        end
        return strobes_after_adds(n - 1, inc) - strobes_after_adds(rel, inc);
    endfunction

    // dot index after a number of strobes, one dot per 4 strobes
    function automatic longint unsigned dot_index(input longint unsigned strobes);
        return (strobes / 4) % 8;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        checks_done++;
        assert (got === expected) else begin
            value_errors++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h at cycle %0d",
                     name, got, expected, cycle_count);
        end
    endtask

    // reference state follows the inputs as the DUT samples them
    always @(posedge sys_clock) begin
        started = 1'b1;
        if (internal_rst) begin
            reset_edge_count++;
            edges_since_release = 0;
            pal_ref = is_pal;
        end else begin
            reset_edge_count = 0;
            edges_since_release++;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge sys_clock) begin : check_outputs
        chip_t           exp_chip;
        longint unsigned dot_inc;
        longint unsigned col_inc;
        longint unsigned adds;
        longint unsigned rel;
        longint unsigned after;
        longint unsigned exp_index;
        logic            exp_dot_en;
        if (started) begin
            exp_chip = pal_ref ? chip_6569 : chip_6567r8;
            dot_inc  = rate_increment(pal_ref ? dot4x_hz_pal : dot4x_hz_ntsc);
            col_inc  = rate_increment(pal_ref ? col4x_hz_pal : col4x_hz_ntsc);
            compare_value("chip", chip, exp_chip);
            if (reset_edge_count > 0) begin
                dot4x_seen = 0;
                col4x_seen = 0;
                compare_value("rst", rst, 1);
                compare_value("dot4x_en", dot4x_en, 0);
                compare_value("col4x_en", col4x_en, 0);
                // phase outputs clear one edge behind the core reset
                if (reset_edge_count > 1) begin
                    compare_value("dot_en", dot_en, 0);
                    compare_value("phi_start", phi_start, 0);
                    compare_value("phi2", phi2, 0);
                    compare_value("dot_count", dot_count, 0);
                end
            end else begin
                // oscillator adds start on the edge after the hold
                adds = 0;
                if (edges_since_release > startup_edges) begin
                    adds = edges_since_release - startup_edges;
                end
                if (dot4x_en) begin
                    dot4x_seen++;
                end
                if (col4x_en) begin
                    col4x_seen++;
                end
                compare_value("dot4x_en count", dot4x_seen, strobes_after_adds(adds, dot_inc));
                compare_value("col4x_en count", col4x_seen, strobes_after_adds(adds, col_inc));
                rel = release_cycle(dot_inc);
                compare_value("rst", rst, adds <= rel);
                after      = strobes_since_release(adds, dot_inc, rel);
                exp_index  = dot_index(after);
                exp_dot_en = 1'b0;
                // dot_en follows the strobe that completes a group of 4
                if (adds > rel + 1) begin
                    if (strobes_after_adds(adds - 1, dot_inc) >
                        strobes_after_adds(adds - 2, dot_inc)) begin
                        exp_dot_en = (after % 4 == 0);
                    end
                end
                compare_value("dot_en", dot_en, exp_dot_en);
                compare_value("phi_start", phi_start, exp_dot_en && exp_index == 0);
                compare_value("phi2", phi2, exp_index >= 4);
                compare_value("dot_count", dot_count, exp_index);
            end
        end
    end

    // run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge sys_clock);
            cycle_count++;
        end
        other_errors++;
        $display("run timed out after %0d cycles", cycle_count);
        $display("errors: %0d value, %0d other, %0d checks", value_errors, other_errors,
                 checks_done);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int   extra;
        logic pal;
        sys_clock           = 1'b0;
        internal_rst        = 1'b1;
        is_pal              = 1'b0;
        started             = 1'b0;
        pal_ref             = 1'b0;
        reset_edge_count    = 0;
        edges_since_release = 0;
        dot4x_seen          = 0;
        col4x_seen          = 0;
        checks_done         = 0;
        value_errors        = 0;
        other_errors        = 0;
        rng_state           = 32'h6f03;

        for (int run = 0; run < 4; run++) begin
            rng_state = xorshift32(rng_state);
            extra     = rng_state[3:0];
            pal       = rng_state[8];
            // first two runs cover both standards
            if (run == 0) begin
                pal = 1'b1;
            end else if (run == 1) begin
                pal = 1'b0;
            end
            $display("run %0d: is_pal %0d, reset %0d cycles", run, pal, 10 + extra);
            // a new run also re-resets the previous one mid-flight
            internal_rst = 1'b1;
            is_pal       = pal;
            repeat (10 + extra) @(negedge sys_clock);
            internal_rst = 1'b0;
            for (int j = 1; j <= int'(startup_edges) + rate_window; j++) begin
                @(negedge sys_clock);
                // strap toggles after reset must not reach chip or rates
                if (j == 1000 || j == 2500) begin
                    is_pal = ~is_pal;
                end
            end
        end

        // final re-reset, then let the last checks settle
        internal_rst = 1'b1;
        repeat (3) @(negedge sys_clock);
        @(posedge sys_clock);

        assert (checks_done > 0) else begin
            other_errors++;
            $display("checker never compared any output");
        end
        $display("errors: %0d value, %0d other, %0d checks", value_errors, other_errors,
                 checks_done);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : tb_vicii_clocks

`default_nettype wire

// ==== vicii_clocks.f ====
design/vicii_clk_pkg.sv
design/clock_nco.sv
design/reset_release.sv
design/clockgen.sv
design/dot_phase_gen.sv
design/vicii_clock_top.sv
bench/tb_vicii_clocks.sv

// ==== Bender.yml ====
package:
  name: vicii_clocks

sources:
  - design/vicii_clk_pkg.sv
  - design/clock_nco.sv
  - design/reset_release.sv
  - design/clockgen.sv
  - design/dot_phase_gen.sv
  - design/vicii_clock_top.sv
  - target: test
    files:
      - bench/tb_vicii_clocks.sv
